//--- Makefile
# Verilator build and run of the line follower testbench

VERILATOR ?= verilator
TOP       ?= tb_line_follower
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --binary --assert --timing -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
hw/lf_pkg.sv
hw/sample_if.sv
hw/adc_reader.sv
hw/motion_sequencer.sv
hw/line_follower_top.sv
sim/adc_model.sv
sim/tb_line_follower.sv

//--- hw/adc_reader.sv
`timescale 1ns/1ps

module adc_reader
	import lf_pkg::*;
#(
	parameter int SCLK_HALF = 10
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic adc_dout,
	output logic adc_sclk,
	output logic adc_cs_n,
	output logic adc_din,
	sample_if.reader samples
);

	localparam int DIV_W = $clog2(SCLK_HALF) + 1;

	// serial clock divider
	logic [DIV_W-1:0] div_cnt;
	logic tick;
	logic sclk_rise;
	logic sclk_fall;

	// frame position
	slot_t slot;
	slot_t slot_next;

	// channel being addressed now and the one addressed last frame
	logic [1:0] chan_ptr;
	logic [1:0] prev_ptr;
	// cleared until one address has gone out
	logic prev_ok;
	chan_addr_t addr_cur;

	// data capture
	sample_t shreg;
	sample_t word;
	logic word_done;

	// chip select tied active, single ADC on the link
	assign adc_cs_n = 1'b0;

	// sclk edges happen on the clk cycle where the divider wraps
	assign tick      = (div_cnt == DIV_W'(SCLK_HALF - 1));
	assign sclk_rise = tick && !adc_sclk;
	assign sclk_fall = tick && adc_sclk;
	assign slot_next = slot + slot_t'(1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			div_cnt  <= '0;
			adc_sclk <= 1'b0;
		end
		else if (tick)
		begin
			div_cnt  <= '0;
			adc_sclk <= !adc_sclk;
		end
		else
		begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	// address order left, centre, right
	always_comb
	begin
		case (chan_ptr)
			2'd0: addr_cur = CH_LEFT;
			2'd1: addr_cur = CH_CENTRE;
			default: addr_cur = CH_RIGHT;
		endcase
	end

	// slot counter, address shifter, channel pointer
	// everything here moves on the sclk falling edge
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			slot     <= '0;
			chan_ptr <= 2'd0;
			prev_ptr <= 2'd0;
			prev_ok  <= 1'b0;
			adc_din  <= 1'b0;
		end
		else if (sclk_fall)
		begin
			slot <= slot_next;
			// address bits MSB first in slots 2..4
			case (slot_next)
				4'd2: adc_din <= addr_cur[2];
				4'd3: adc_din <= addr_cur[1];
				4'd4: adc_din <= addr_cur[0];
				default: adc_din <= 1'b0;
			endcase
			// end of frame, next frame returns this address's data
			if (slot == 4'd15)
			begin
				prev_ptr <= chan_ptr;
				chan_ptr <= (chan_ptr == 2'd2) ? 2'd0 : chan_ptr + 2'd1;
				prev_ok  <= 1'b1;
			end
		end
	end

	// last bit arrives on the slot 15 rising edge
	assign word      = {shreg[10:0], adc_dout};
	assign word_done = sclk_rise && (slot == 4'd15) && prev_ok;

	always_ff @(posedge clk)
	begin
		if (sclk_rise && (slot >= 4'd4))
			shreg <= word;
		if (word_done)
		begin
			case (prev_ptr)
				2'd0: samples.left <= word;
				2'd1: samples.centre <= word;
				default: samples.right <= word;
			endcase
		end
	end

	// scan complete once right is in
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			samples.valid <= 1'b0;
		else
			samples.valid <= word_done && (prev_ptr == 2'd2);
	end

	// one store per frame, so never two strobes back to back
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		samples.valid |=> !samples.valid);

	// din quiet outside the address window
	a_din_window: assert property (@(posedge clk) disable iff (!rst_n)
		!(slot inside {4'd2, 4'd3, 4'd4}) |-> !adc_din);

endmodule

//--- hw/lf_pkg.sv
package lf_pkg;

	// one 12-bit conversion result from the ADC
	typedef logic [11:0] sample_t;

	// wheel burst length, also used as the burst down-counter
	typedef logic [7:0] burst_t;

	// serial clock period index inside one 16-slot ADC frame
	typedef logic [3:0] slot_t;

	// ADC channel select, sent MSB first on din
	typedef logic [2:0] chan_addr_t;

	// line sensor channels on the ADC
	localparam chan_addr_t CH_LEFT   = 3'd5;
	localparam chan_addr_t CH_CENTRE = 3'd6;
	localparam chan_addr_t CH_RIGHT  = 3'd7;

	// robot moves picked from the sensor pattern
	typedef enum logic [2:0]
	{
		MOVE_STOP,
		MOVE_FORWARD,
		MOVE_BACK,
		// left wheel forward only
		MOVE_VEER_RIGHT,
		// right wheel forward only
		MOVE_VEER_LEFT
	} move_t;

endpackage

//--- hw/line_follower_top.sv
`timescale 1ns/1ps

module line_follower_top
#(
	parameter int          SCLK_HALF       = 10,
	parameter logic [11:0] WHITE_THRESHOLD = 12'd1242,
	parameter logic [7:0]  LEFT_BURST      = 8'd40,
	parameter logic [7:0]  RIGHT_BURST     = 8'd250
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic adc_dout,
	output logic adc_sclk,
	output logic adc_cs_n,
	output logic adc_din,
	output logic rw_f,
	output logic rw_b,
	output logic lw_f,
	output logic lw_b
);

	// scan hand-off between reader and sequencer
	sample_if smp ();

	// serial link to the sensor ADC
	adc_reader #(
		.SCLK_HALF(SCLK_HALF)
	) u_reader (
		.clk     (clk),
		.rst_n   (rst_n),
		.adc_dout(adc_dout),
		.adc_sclk(adc_sclk),
		.adc_cs_n(adc_cs_n),
		.adc_din (adc_din),
		.samples (smp.reader)
	);

	// decision and wheel bursts
	motion_sequencer #(
		.WHITE_THRESHOLD(WHITE_THRESHOLD),
		.LEFT_BURST     (LEFT_BURST),
		.RIGHT_BURST    (RIGHT_BURST)
	) u_seq (
		.clk    (clk),
		.rst_n  (rst_n),
		.samples(smp.sequencer),
		.rw_f   (rw_f),
		.rw_b   (rw_b),
		.lw_f   (lw_f),
		.lw_b   (lw_b)
	);

endmodule

//--- hw/motion_sequencer.sv
`timescale 1ns/1ps

module motion_sequencer
	import lf_pkg::*;
#(
	parameter sample_t WHITE_THRESHOLD = 12'd1242,
	parameter burst_t  LEFT_BURST      = 8'd40,
	parameter burst_t  RIGHT_BURST     = 8'd250
)
(
	input  logic clk,
	input  logic rst_n,
	sample_if.sequencer samples,
	output logic rw_f,
	output logic rw_b,
	output logic lw_f,
	output logic lw_b
);

	typedef enum logic [1:0]
	{
		ST_DECIDE,
		ST_BURST,
		ST_STOP
	} state_t;

	state_t state;

	// black when strictly above the white level
	logic l_blk;
	logic c_blk;
	logic r_blk;
	move_t move_d;

	// wheel drive for the decided move
	logic l_fwd;
	logic l_bwd;
	logic r_fwd;
	logic r_bwd;

	// remaining high cycles per wheel, zero when idle
	burst_t l_cnt;
	burst_t r_cnt;
	logic l_last;
	logic r_last;

	always_comb
	begin
		l_blk = (samples.left > WHITE_THRESHOLD);
		c_blk = (samples.centre > WHITE_THRESHOLD);
		r_blk = (samples.right > WHITE_THRESHOLD);
		// pattern is L C R
		case ({l_blk, c_blk, r_blk})
			3'b000: move_d = MOVE_BACK;
			3'b001: move_d = MOVE_VEER_RIGHT;
			3'b010: move_d = MOVE_FORWARD;
			3'b011: move_d = MOVE_VEER_RIGHT;
			3'b100: move_d = MOVE_VEER_LEFT;
			3'b110: move_d = MOVE_VEER_LEFT;
			// 101 and 111, junction or nonsense
			default: move_d = MOVE_STOP;
		endcase
	end

	always_comb
	begin
		l_fwd = 1'b0;
		l_bwd = 1'b0;
		r_fwd = 1'b0;
		r_bwd = 1'b0;
		case (move_d)
			MOVE_FORWARD:
			begin
				l_fwd = 1'b1;
				r_fwd = 1'b1;
			end
			MOVE_BACK:
			begin
				l_bwd = 1'b1;
				r_bwd = 1'b1;
			end
			MOVE_VEER_RIGHT: l_fwd = 1'b1;
			MOVE_VEER_LEFT: r_fwd = 1'b1;
			default: ;
		endcase
	end

	// wheel done on its final high cycle, or if never driven
	assign l_last = (l_cnt <= burst_t'(1));
	assign r_last = (r_cnt <= burst_t'(1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= ST_DECIDE;
			l_cnt <= '0;
			r_cnt <= '0;
			lw_f  <= 1'b0;
			lw_b  <= 1'b0;
			rw_f  <= 1'b0;
			rw_b  <= 1'b0;
		end
		else
		begin
			case (state)
				ST_DECIDE:
				begin
					// scans arriving mid-burst never reach here
					if (samples.valid)
					begin
						if (move_d == MOVE_STOP)
						begin
							state <= ST_STOP;
						end
						else
						begin
							state <= ST_BURST;
							lw_f  <= l_fwd;
							lw_b  <= l_bwd;
							rw_f  <= r_fwd;
							rw_b  <= r_bwd;
							l_cnt <= (l_fwd || l_bwd) ? LEFT_BURST : '0;
							r_cnt <= (r_fwd || r_bwd) ? RIGHT_BURST : '0;
						end
					end
				end
				ST_BURST:
				begin
					if (l_last)
					begin
						l_cnt <= '0;
						lw_f  <= 1'b0;
						lw_b  <= 1'b0;
					end
					else
					begin
						l_cnt <= l_cnt - burst_t'(1);
					end
					if (r_last)
					begin
						r_cnt <= '0;
						rw_f  <= 1'b0;
						rw_b  <= 1'b0;
					end
					else
					begin
						r_cnt <= r_cnt - burst_t'(1);
					end
					// both wheels through, back to waiting
					if (l_last && r_last)
						state <= ST_DECIDE;
				end
				// wheels already low, one idle cycle
				ST_STOP: state <= ST_DECIDE;
				default: state <= ST_DECIDE;
			endcase
		end
	end

	a_no_shoot: assert property (@(posedge clk) disable iff (!rst_n)
		!(lw_f && lw_b) && !(rw_f && rw_b));

	// a finished burst leaves nothing driven
	a_decide_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_DECIDE) |-> !(lw_f || lw_b || rw_f || rw_b));

endmodule

//--- hw/sample_if.sv
`timescale 1ns/1ps

interface sample_if
	import lf_pkg::*;
();
	// one full scan, left/centre/right line sensors
	sample_t left;
	sample_t centre;
	sample_t right;
	// single-cycle strobe, samples hold until the next one
	logic valid;

	modport reader
	(
		output left,
		output centre,
		output right,
		output valid
	);

	modport sequencer
	(
		input left,
		input centre,
		input right,
		input valid
	);

endinterface

//--- sim/adc_model.sv
`timescale 1ns/1ps

module adc_model
	import lf_pkg::*;
(
	input  logic adc_sclk,
	input  logic adc_din,
	output logic adc_dout = 1'b0,
	input  sample_t left_val,
	input  sample_t centre_val,
	input  sample_t right_val,
	output chan_addr_t last_addr,
	output int addr_count,
	output int load_count
);

	// slot of the most recent sclk rise
	slot_t slot = 4'd0;
	// no real rise seen yet, the reset edge of sclk is not a slot
	logic started = 1'b0;
	logic [1:0] addr_sh = 2'b00;
	sample_t word = '0;

	// address decode, three bits MSB first in slots 2..4
	always @(posedge adc_sclk)
	begin
		if (started)
			slot = slot + 4'd1;
		else
			slot = 4'd0;
		started = 1'b1;
		if (slot == 4'd2 || slot == 4'd3)
			addr_sh = {addr_sh[0], adc_din};
		if (slot == 4'd4)
		begin
			last_addr = {addr_sh, adc_din};
			addr_count = addr_count + 1;
		end
	end

	// data out on the falls ending slots 3..14
	always @(negedge adc_sclk)
	begin
		if (started && slot == 4'd3)
		begin
			// last_addr still holds the address of the previous frame
			case (last_addr)
				CH_LEFT: word = left_val;
				CH_CENTRE: word = centre_val;
				CH_RIGHT: word = right_val;
				default: word = '0;
			endcase
			load_count = load_count + 1;
		end
		if (started && slot >= 4'd3 && slot <= 4'd14)
		begin
			adc_dout <= word[11];
			word = {word[10:0], 1'b0};
		end
		else
			adc_dout <= 1'b0;
	end

endmodule

//--- sim/tb_line_follower.sv
`timescale 1ns/1ps

module tb_line_follower
	import lf_pkg::*;
();

	localparam int SCLK_HALF = 2;
	localparam int WHITE = 1242;
	localparam int LEFT_BURST = 40;
	localparam int RIGHT_BURST = 250;
	localparam int NUM_TESTS = 28;
	localparam int FRAME = 32 * SCLK_HALF;
	// settle, drain a mixed burst, one scan, the checked burst, with slack
	localparam int TEST_CYCLES = 9 * FRAME + 3 * RIGHT_BURST;
	localparam int MAX_CYCLES = NUM_TESTS * TEST_CYCLES + 1000;

	logic clk;
	logic rst_n;
	logic adc_dout;
	logic adc_sclk;
	logic adc_cs_n;
	logic adc_din;
	logic rw_f;
	logic rw_b;
	logic lw_f;
	logic lw_b;
	// lw_f lw_b rw_f rw_b
	logic [3:0] wheels;
	logic [3:0] exp_wheels;
	// high once the programmed values have fully reached the sequencer
	logic checking;
	sample_t left_val;
	sample_t centre_val;
	sample_t right_val;
	chan_addr_t last_addr;
	int addr_count;
	int load_count;
	int seed;
	int run_len [4];
	int cycle_cnt = 0;
	int value_errs = 0;
	int other_errs = 0;

	assign wheels = {lw_f, lw_b, rw_f, rw_b};

	line_follower_top #(
		.SCLK_HALF(SCLK_HALF)
	) dut0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.adc_dout(adc_dout),
		.adc_sclk(adc_sclk),
		.adc_cs_n(adc_cs_n),
		.adc_din (adc_din),
		.rw_f    (rw_f),
		.rw_b    (rw_b),
		.lw_f    (lw_f),
		.lw_b    (lw_b)
	);

	adc_model adc0 (
		.adc_sclk  (adc_sclk),
		.adc_din   (adc_din),
		.adc_dout  (adc_dout),
		.left_val  (left_val),
		.centre_val(centre_val),
		.right_val (right_val),
		.last_addr (last_addr),
		.addr_count(addr_count),
		.load_count(load_count)
	);

	// move table, pattern is L C R with 1 for black
	function automatic logic [3:0] wheels_for(input logic [2:0] pat);
		case (pat)
			3'b000: return 4'b0101;
			3'b001, 3'b011: return 4'b1000;
			3'b010: return 4'b1010;
			3'b100, 3'b110: return 4'b0010;
			default: return 4'b0000;
		endcase
	endfunction

	function automatic sample_t sensor_value(input logic black, input logic at_edge, input int r);
		int mag;
		mag = r & 32'h7fff_ffff;
		// white is the threshold itself, black one above it
		if (at_edge || (mag % 5 == 0))
			return black ? sample_t'(WHITE + 1) : sample_t'(WHITE);
		if (black)
			return sample_t'(WHITE + 1 + mag % (4095 - WHITE));
		return sample_t'(mag % (WHITE + 1));
	endfunction

	// bits 3 and 2 belong to the left wheel
	function automatic int burst_len(input int idx);
		return (idx >= 2) ? LEFT_BURST : RIGHT_BURST;
	endfunction

	// frames count from one, left first
	function automatic chan_addr_t addr_for_frame(input int n);
		case ((n - 1) % 3)
			0: return CH_LEFT;
			1: return CH_CENTRE;
			default: return CH_RIGHT;
		endcase
	endfunction

	task automatic run_test(input int idx);
		logic [2:0] pat;
		logic edge_vals;
		int start;
		// all eight patterns first, every sensor on a threshold edge
		if (idx < 8)
		begin
			pat = 3'(idx);
			edge_vals = 1'b1;
		end
		else
		begin
			pat = 3'($random(seed));
			edge_vals = 1'b0;
		end
		@(posedge clk);
		while (wheels != 4'b0000)
			@(posedge clk);
		left_val <= sensor_value(pat[2], edge_vals, $random(seed));
		centre_val <= sensor_value(pat[1], edge_vals, $random(seed));
		right_val <= sensor_value(pat[0], edge_vals, $random(seed));
		exp_wheels <= wheels_for(pat);
		checking <= 1'b0;
		// two full scans, nothing stale left in flight
		start = load_count;
		while (load_count < start + 6)
			@(posedge clk);
		// a burst from a mixed scan may still be running
		while (wheels != 4'b0000)
			@(posedge clk);
		checking <= 1'b1;
		if (wheels_for(pat) == 4'b0000)
		begin
			// stop, watch at least one more scan
			start = load_count;
			while (load_count < start + 4)
				@(posedge clk);
		end
		else
		begin
			while (wheels == 4'b0000)
				@(posedge clk);
			while (wheels != 4'b0000)
				@(posedge clk);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// run lengths of each wheel output
	always @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
			run_len[i] <= wheels[i] ? run_len[i] + 1 : 0;
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("timeout: tests still running after %0d cycles", cycle_cnt);
			$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
			$display("TEST FAIL");
			$finish;
		end
	end

	a_reset_low: assert property (@(posedge clk)
		(cycle_cnt > 0 && $past(!rst_n)) |->
		(wheels == 4'b0000 && !adc_sclk && !adc_din && !adc_cs_n))
	else
	begin
		other_errs++;
		$display("outputs were not all low during or right after reset");
	end

	a_addr_order: assert property (@(posedge clk) disable iff (!rst_n)
		(addr_count != $past(addr_count)) |-> last_addr == addr_for_frame(addr_count))
	else
	begin
		value_errs++;
		$display("Error addr_order: expected %0d actual %0d",
			addr_for_frame($sampled(addr_count)), $sampled(last_addr));
	end

	// first cycle of a burst shows the whole move
	a_move: assert property (@(posedge clk) disable iff (!rst_n)
		(checking && wheels != 4'b0000 && $past(wheels) == 4'b0000) |-> wheels == exp_wheels)
	else
	begin
		value_errs++;
		$display("Error move: expected %b actual %b", $sampled(exp_wheels), $sampled(wheels));
	end

	a_stop_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(checking && exp_wheels == 4'b0000) |-> wheels == 4'b0000)
	else
	begin
		value_errs++;
		$display("Error stop_idle: expected 0000 actual %b", $sampled(wheels));
	end

	for (genvar i = 0; i < 4; i++)
	begin : g_len
		a_len: assert property (@(posedge clk) disable iff (!rst_n)
			(!wheels[i] && $past(wheels[i])) |-> run_len[i] == burst_len(i))
		else
		begin
			value_errs++;
			$display("Error burst_len[%0d]: expected %0d actual %0d",
				i, burst_len(i), $sampled(run_len[i]));
		end
	end

	a_no_shoot: assert property (@(posedge clk) disable iff (!rst_n)
		!(lw_f && lw_b) && !(rw_f && rw_b))
	else
	begin
		other_errs++;
		$display("a wheel was driven forward and backward at the same time");
	end

	initial
	begin
		seed = 32'hee54;
		rst_n = 1'b0;
		left_val = sample_t'(WHITE);
		centre_val = sample_t'(WHITE);
		right_val = sample_t'(WHITE);
		exp_wheels = 4'b0000;
		checking = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		repeat (2) @(posedge clk);
		$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
